/* src.f */
+incdir+design
design/fndTimePkg.sv
design/fndPanelPkg.sv
design/timeDigitSplit.sv
design/timeCapture.sv
design/scanSequencer.sv
design/segmentDriver.sv
design/fndController.sv
dv/fndController_properties.sv
dv/fndController_tb.sv

/* Makefile */
# Verilator build and run for the seven-segment display controller

VERILATOR ?= verilator
TOP       ?= fndController_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/fndController_tb.sv */
module fndController_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int scanDivideTb = 8;
    localparam int scanPeriod   = 4 * scanDivideTb;
    localparam int waitLimit    = 2 * scanPeriod;

    logic                      iClk;
    logic                      iRst;
    fndTimePkg::timeWord_t     timeData;
    fndPanelPkg::displayMode_t mode;
    logic                      alarmEnd;
    fndPanelPkg::segment_t     segment;
    fndPanelPkg::digitEnable_t digitEnable;
    fndPanelPkg::modeLed_t     modeLed;
    fndPanelPkg::alarmLed_t    alarmLed;

    fndController #(.scanDivide(scanDivideTb)) u_fndController
    (
        .iClk        (iClk),
        .iRst        (iRst),
        .timeData    (timeData),
        .mode        (mode),
        .alarmEnd    (alarmEnd),
        .segment     (segment),
        .digitEnable (digitEnable),
        .modeLed     (modeLed),
        .alarmLed    (alarmLed)
    );

    bind fndController fndControllerProperties u_fndControllerProperties (.*);

    initial
    begin
        iClk = 1'b0;
        forever #10 iClk = ~iClk;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic fndTimePkg::timeWord_t packTime(int h, int m, int s, int c);
        return {h[4:0], m[5:0], s[5:0], c[6:0]};
    endfunction

    // Common anode table, dot off
    function automatic fndPanelPkg::segment_t encodeDigit(int value);
        case (value)
            0:       return 8'hC0;
            1:       return 8'hF9;
            2:       return 8'hA4;
            3:       return 8'hB0;
            4:       return 8'h99;
            5:       return 8'h92;
            6:       return 8'h82;
            7:       return 8'hF8;
            8:       return 8'h80;
            9:       return 8'h90;
            default: return 8'hFF;
        endcase
    endfunction

    function automatic fndPanelPkg::segment_t expectedSegment(int modeVal, int p, int h, int m,
                                                              int s, int c);
        bit                    hourPage;
        int                    value;
        fndPanelPkg::segment_t pattern;
        // Only the three valid odd modes show hours
        hourPage = (modeVal == 1) || (modeVal == 3) || (modeVal == 5);
        case (p)
            0:       value = hourPage ? m % 10 : c % 10;
            1:       value = hourPage ? m / 10 : c / 10;
            2:       value = hourPage ? h % 10 : s % 10;
            default: value = hourPage ? h / 10 : s / 10;
        endcase
        pattern = encodeDigit(value);
        if (p == 2 && c >= 50)
            pattern[7] = 1'b0;
        return pattern;
    endfunction

    //////////////////////////////
    // Checking
    //////////////////////////////
    task automatic stopOnFailure(string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    // Any bound assertion failure ends the run at once
    always @(u_fndController.u_fndControllerProperties.failCount)
    begin
        if (u_fndController.u_fndControllerProperties.failCount != 0)
            stopOnFailure("A bound assertion on the display outputs failed");
    end

    task automatic segmentCompare(fndPanelPkg::segment_t expVal);
        if (segment !== expVal)
            stopOnFailure($sformatf("[FAIL] t=%0t segment expected 8'h%h actual 8'h%h",
                                    $time, expVal, segment));
    endtask

    task automatic enableCompare(fndPanelPkg::digitEnable_t expVal);
        if (digitEnable !== expVal)
            stopOnFailure($sformatf("[FAIL] t=%0t digitEnable expected 4'b%b actual 4'b%b",
                                    $time, expVal, digitEnable));
    endtask

    task automatic modeLedCompare(fndPanelPkg::modeLed_t expVal);
        if (modeLed !== expVal)
            stopOnFailure($sformatf("[FAIL] t=%0t modeLed expected 6'b%b actual 6'b%b",
                                    $time, expVal, modeLed));
    endtask

    task automatic alarmLedCompare(fndPanelPkg::alarmLed_t expVal);
        if (alarmLed !== expVal)
            stopOnFailure($sformatf("[FAIL] t=%0t alarmLed expected 4'b%b actual 4'b%b",
                                    $time, expVal, alarmLed));
    endtask

    task automatic applyInputs(int h, int m, int s, int c, int modeVal, bit alarm);
        @(posedge iClk);
        timeData <= packTime(h, m, s, c);
        mode     <= fndPanelPkg::displayMode_t'(modeVal[2:0]);
        alarmEnd <= alarm;
    endtask

    task automatic waitForEnable(int p);
        fndPanelPkg::digitEnable_t target;
        int                        cycles;
        target = ~(fndPanelPkg::digitEnable_t'(1) << p);
        cycles = 0;
        @(negedge iClk);
        while (digitEnable !== target)
        begin
            if (cycles >= waitLimit)
                stopOnFailure($sformatf("Digit position %0d was never enabled within %0d clocks",
                                        p, waitLimit));
            cycles++;
            @(negedge iClk);
        end
    endtask

    // Let two full scans pass, then visit every position once
    task automatic scanCheck(int h, int m, int s, int c, int modeVal);
        repeat (2 * scanPeriod) @(negedge iClk);
        for (int p = 0; p < 4; p++)
        begin
            waitForEnable(p);
            segmentCompare(expectedSegment(modeVal, p, h, m, s, c));
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic checkResetState();
        repeat (8) @(posedge iClk);
        @(negedge iClk);
        segmentCompare(8'hFF);
        enableCompare(4'b1111);
        modeLedCompare('0);
        alarmLedCompare('0);
        repeat (8) @(posedge iClk);
        iRst <= 1'b0;
        @(negedge iClk);
        segmentCompare(8'hFF);
        enableCompare(4'b1111);
        modeLedCompare('0);
        alarmLedCompare('0);
        // Still dark before the first scan step
        repeat (4) @(negedge iClk);
        segmentCompare(8'hFF);
        enableCompare(4'b1111);
    endtask

    task automatic showHourPage();
        applyInputs(13, 47, 29, 61, 5, 1'b0);
        repeat (2) @(negedge iClk);
        modeLedCompare(6'b10_0000);
        scanCheck(13, 47, 29, 61, 5);
    endtask

    task automatic blinkSecondsDot();
        applyInputs(9, 5, 42, 23, 0, 1'b0);
        scanCheck(9, 5, 42, 23, 0);
        applyInputs(9, 5, 42, 78, 0, 1'b0);
        scanCheck(9, 5, 42, 78, 0);
    endtask

    task automatic sweepModeLeds();
        fndPanelPkg::modeLed_t expLed;
        for (int modeVal = 0; modeVal < 8; modeVal++)
        begin
            expLed = (modeVal < 6) ? fndPanelPkg::modeLed_t'(1 << modeVal) : '0;
            applyInputs(21, 38, 17, 64, modeVal, 1'b0);
            repeat (2) @(negedge iClk);
            modeLedCompare(expLed);
            scanCheck(21, 38, 17, 64, modeVal);
        end
    endtask

    task automatic alarmPattern();
        applyInputs(7, 30, 0, 10, 0, 1'b0);
        repeat (3) @(negedge iClk);
        alarmLedCompare(4'b0000);
        applyInputs(7, 30, 0, 10, 0, 1'b1);
        repeat (3) @(negedge iClk);
        alarmLedCompare(4'b0101);
        applyInputs(7, 30, 0, 90, 0, 1'b1);
        repeat (3) @(negedge iClk);
        alarmLedCompare(4'b1010);
    endtask

    task automatic randomTimes();
        int h;
        int m;
        int s;
        int c;
        int modeVal;
        for (int n = 0; n < 20; n++)
        begin
            h       = $urandom_range(23, 0);
            m       = $urandom_range(59, 0);
            s       = $urandom_range(59, 0);
            c       = $urandom_range(99, 0);
            modeVal = $urandom_range(5, 0);
            applyInputs(h, m, s, c, modeVal, 1'b0);
            scanCheck(h, m, s, c, modeVal);
        end
    endtask

    initial
    begin
        void'($urandom(59027));
        iRst       = 1'b1;
        timeData   = '0;
        mode       = fndPanelPkg::clockSec;
        alarmEnd   = 1'b0;
        checkResetState();
        showHourPage();
        blinkSecondsDot();
        sweepModeLeds();
        alarmPattern();
        randomTimes();
        if (u_fndController.u_fndControllerProperties.failCount == 0)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
            stopOnFailure("Bound assertions failed during the run");
    end

endmodule

/* dv/fndController_properties.sv */
module fndControllerProperties
(
    input logic                      iClk,
    input logic                      iRst,
    input fndPanelPkg::segment_t     segment,
    input fndPanelPkg::digitEnable_t digitEnable,
    input fndPanelPkg::modeLed_t     modeLed,
    input fndPanelPkg::alarmLed_t    alarmLed
);

    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    //////////////////////////////
    // Output shape
    //////////////////////////////
    enableOneLow: assert property (@(posedge iClk) disable iff (iRst)
        (digitEnable == '1) || $onehot(~digitEnable))
        else
        begin
            failCount++;
            $error("More than one digit enabled: %b", digitEnable);
        end

    alarmLegal: assert property (@(posedge iClk) disable iff (iRst)
        (alarmLed == 4'b0000) || (alarmLed == 4'b0101) || (alarmLed == 4'b1010))
        else
        begin
            failCount++;
            $error("Alarm LEDs outside the alternating pair: %b", alarmLed);
        end

    modeLedOneHot: assert property (@(posedge iClk) disable iff (iRst) $onehot0(modeLed))
        else
        begin
            failCount++;
            $error("Several mode LEDs lit: %b", modeLed);
        end

    // Flops clear on the edge that sees reset
    resetValues: assert property (@(posedge iClk) iRst |=>
        (segment == 8'hFF && digitEnable == '1 && modeLed == '0 && alarmLed == '0))
        else
        begin
            failCount++;
            $error("Outputs not at reset values while reset held");
        end

endmodule

/* design/fndController.sv */
`include "fnd_settings.svh"

module fndController
#(
    parameter int scanDivide = `FND_SCAN_DIV
)
(
    input  logic                      iClk,
    input  logic                      iRst,
    input  fndTimePkg::timeWord_t     timeData,
    input  fndPanelPkg::displayMode_t mode,
    input  logic                      alarmEnd,
    output fndPanelPkg::segment_t     segment,
    output fndPanelPkg::digitEnable_t digitEnable,
    output fndPanelPkg::modeLed_t     modeLed,
    output fndPanelPkg::alarmLed_t    alarmLed
);

    fndTimePkg::bcdDigit_t  hourTens;
    fndTimePkg::bcdDigit_t  hourOnes;
    fndTimePkg::bcdDigit_t  minTens;
    fndTimePkg::bcdDigit_t  minOnes;
    fndTimePkg::bcdDigit_t  secTens;
    fndTimePkg::bcdDigit_t  secOnes;
    fndTimePkg::bcdDigit_t  centiTens;
    fndTimePkg::bcdDigit_t  centiOnes;
    logic                   dotPhase;
    fndPanelPkg::position_t position;
    fndTimePkg::bcdDigit_t  digit;
    logic                   dotOn;

    //////////////////////////////
    // Input side
    //////////////////////////////
    timeCapture u_timeCapture
    (
        .iClk      (iClk),
        .iRst      (iRst),
        .timeData  (timeData),
        .hourTens  (hourTens),
        .hourOnes  (hourOnes),
        .minTens   (minTens),
        .minOnes   (minOnes),
        .secTens   (secTens),
        .secOnes   (secOnes),
        .centiTens (centiTens),
        .centiOnes (centiOnes),
        .dotPhase  (dotPhase)
    );

    //////////////////////////////
    // Scan and output side
    //////////////////////////////
    scanSequencer #(.scanDivide(scanDivide)) u_scanSequencer
    (
        .iClk      (iClk),
        .iRst      (iRst),
        .mode      (mode),
        .hourTens  (hourTens),
        .hourOnes  (hourOnes),
        .minTens   (minTens),
        .minOnes   (minOnes),
        .secTens   (secTens),
        .secOnes   (secOnes),
        .centiTens (centiTens),
        .centiOnes (centiOnes),
        .dotPhase  (dotPhase),
        .position  (position),
        .digit     (digit),
        .dotOn     (dotOn)
    );

    segmentDriver u_segmentDriver
    (
        .iClk        (iClk),
        .iRst        (iRst),
        .position    (position),
        .digit       (digit),
        .dotOn       (dotOn),
        .mode        (mode),
        .alarmEnd    (alarmEnd),
        .dotPhase    (dotPhase),
        .segment     (segment),
        .digitEnable (digitEnable),
        .modeLed     (modeLed),
        .alarmLed    (alarmLed)
    );

endmodule

/* design/segmentDriver.sv */
module segmentDriver
(
    input  logic                      iClk,
    input  logic                      iRst,
    input  fndPanelPkg::position_t    position,
    input  fndTimePkg::bcdDigit_t     digit,
    input  logic                      dotOn,
    input  fndPanelPkg::displayMode_t mode,
    input  logic                      alarmEnd,
    input  logic                      dotPhase,
    output fndPanelPkg::segment_t     segment,
    output fndPanelPkg::digitEnable_t digitEnable,
    output fndPanelPkg::modeLed_t     modeLed,
    output fndPanelPkg::alarmLed_t    alarmLed
);

    logic                   scanActive;
    logic                   litNow;
    fndPanelPkg::segment_t  pattern;
    fndPanelPkg::modeLed_t  modeLedNext;
    fndPanelPkg::alarmLed_t alarmLedNext;

    //////////////////////////////
    // Segment encoding
    //////////////////////////////
    always_comb
    begin
        case (digit)
            4'd0:    pattern = 8'hC0;
            4'd1:    pattern = 8'hF9;
            4'd2:    pattern = 8'hA4;
            4'd3:    pattern = 8'hB0;
            4'd4:    pattern = 8'h99;
            4'd5:    pattern = 8'h92;
            4'd6:    pattern = 8'h82;
            4'd7:    pattern = 8'hF8;
            4'd8:    pattern = 8'h80;
            4'd9:    pattern = 8'h90;
            default: pattern = 8'hFF;
        endcase
        if (dotOn)
            pattern[7] = 1'b0;
    end

    // Dark until the sequencer reaches position 0 for the first time
    assign litNow = scanActive || (position == '0);

    //////////////////////////////
    // LED decode
    //////////////////////////////
    always_comb
    begin
        case (mode)
            fndPanelPkg::clockSec:      modeLedNext = 6'b00_0001;
            fndPanelPkg::clockHour:     modeLedNext = 6'b00_0010;
            fndPanelPkg::stopwatchSec:  modeLedNext = 6'b00_0100;
            fndPanelPkg::stopwatchHour: modeLedNext = 6'b00_1000;
            fndPanelPkg::timerSec:      modeLedNext = 6'b01_0000;
            fndPanelPkg::timerHour:     modeLedNext = 6'b10_0000;
            default:                    modeLedNext = '0;
        endcase
    end

    // Alternating pair swaps every half second
    assign alarmLedNext = !alarmEnd ? 4'b0000 : (dotPhase ? 4'b1010 : 4'b0101);

    always_ff @(posedge iClk or posedge iRst)
    begin
        if (iRst)
        begin
            scanActive  <= 1'b0;
            segment     <= 8'hFF;
            digitEnable <= '1;
            modeLed     <= '0;
            alarmLed    <= '0;
        end
        else
        begin
            scanActive <= litNow;
            if (litNow)
            begin
                segment     <= pattern;
                digitEnable <= ~(fndPanelPkg::digitEnable_t'(1) << position);
            end
            modeLed  <= modeLedNext;
            alarmLed <= alarmLedNext;
        end
    end

endmodule

/* design/scanSequencer.sv */
`include "fnd_settings.svh"

module scanSequencer
#(
    parameter int scanDivide = `FND_SCAN_DIV
)
(
    input  logic                     iClk,
    input  logic                     iRst,
    input  fndPanelPkg::displayMode_t mode,
    input  fndTimePkg::bcdDigit_t    hourTens,
    input  fndTimePkg::bcdDigit_t    hourOnes,
    input  fndTimePkg::bcdDigit_t    minTens,
    input  fndTimePkg::bcdDigit_t    minOnes,
    input  fndTimePkg::bcdDigit_t    secTens,
    input  fndTimePkg::bcdDigit_t    secOnes,
    input  fndTimePkg::bcdDigit_t    centiTens,
    input  fndTimePkg::bcdDigit_t    centiOnes,
    input  logic                     dotPhase,
    output fndPanelPkg::position_t   position,
    output fndTimePkg::bcdDigit_t    digit,
    output logic                     dotOn
);

    localparam int divWidth = (scanDivide > 2) ? $clog2(scanDivide) : 1;

    logic [divWidth-1:0]    divCount;
    logic                   scanStep;
    logic                   hourPage;
    fndPanelPkg::position_t nextPosition;
    fndTimePkg::bcdDigit_t  nextDigit;

    //////////////////////////////
    // Scan divider
    //////////////////////////////
    assign scanStep = (divCount == divWidth'(scanDivide - 1));

    always_ff @(posedge iClk or posedge iRst)
    begin
        if (iRst)
            divCount <= '0;
        else if (scanStep)
            divCount <= '0;
        else
            divCount <= divCount + 1'b1;
    end

    //////////////////////////////
    // Page and digit select
    //////////////////////////////
    assign nextPosition = fndPanelPkg::position_t'(position + 1'b1);

    // Invalid modes fall back to the seconds page
    always_comb
    begin
        case (mode)
            fndPanelPkg::clockHour,
            fndPanelPkg::stopwatchHour,
            fndPanelPkg::timerHour: hourPage = 1'b1;
            default:                hourPage = 1'b0;
        endcase
    end

    always_comb
    begin
        case ({hourPage, nextPosition})
            3'b1_00: nextDigit = minOnes;
            3'b1_01: nextDigit = minTens;
            3'b1_10: nextDigit = hourOnes;
            3'b1_11: nextDigit = hourTens;
            3'b0_00: nextDigit = centiOnes;
            3'b0_01: nextDigit = centiTens;
            3'b0_10: nextDigit = secOnes;
            default: nextDigit = secTens;
        endcase
    end

    // Position, digit and dot move on the same edge
    always_ff @(posedge iClk or posedge iRst)
    begin
        if (iRst)
        begin
            position <= fndPanelPkg::position_t'(`FND_DIGITS - 1);
            digit    <= '0;
            dotOn    <= 1'b0;
        end
        else if (scanStep)
        begin
            position <= nextPosition;
            digit    <= nextDigit;
            dotOn    <= dotPhase && (nextPosition == fndPanelPkg::position_t'(2));
        end
    end

endmodule

/* design/timeCapture.sv */
`include "fnd_settings.svh"

module timeCapture
(
    input  logic                  iClk,
    input  logic                  iRst,
    input  fndTimePkg::timeWord_t timeData,
    output fndTimePkg::bcdDigit_t hourTens,
    output fndTimePkg::bcdDigit_t hourOnes,
    output fndTimePkg::bcdDigit_t minTens,
    output fndTimePkg::bcdDigit_t minOnes,
    output fndTimePkg::bcdDigit_t secTens,
    output fndTimePkg::bcdDigit_t secOnes,
    output fndTimePkg::bcdDigit_t centiTens,
    output fndTimePkg::bcdDigit_t centiOnes,
    output logic                  dotPhase
);

    fndTimePkg::hour_t     hourField;
    fndTimePkg::minute_t   minField;
    fndTimePkg::second_t   secField;
    fndTimePkg::centi_t    centiField;
    fndTimePkg::bcdDigit_t splitDigits [8];

    //////////////////////////////
    // Field slicing
    //////////////////////////////
    assign hourField  = timeData[`FND_HOUR_MSB:`FND_HOUR_LSB];
    assign minField   = timeData[`FND_MIN_MSB:`FND_MIN_LSB];
    assign secField   = timeData[`FND_SEC_MSB:`FND_SEC_LSB];
    assign centiField = timeData[`FND_CSEC_MSB:`FND_CSEC_LSB];

    // Even index tens, odd index ones
    timeDigitSplit #(.tField(fndTimePkg::hour_t)) u_hourSplit
    (
        .value (hourField),
        .tens  (splitDigits[0]),
        .ones  (splitDigits[1])
    );

    timeDigitSplit #(.tField(fndTimePkg::minute_t)) u_minSplit
    (
        .value (minField),
        .tens  (splitDigits[2]),
        .ones  (splitDigits[3])
    );

    timeDigitSplit #(.tField(fndTimePkg::second_t)) u_secSplit
    (
        .value (secField),
        .tens  (splitDigits[4]),
        .ones  (splitDigits[5])
    );

    timeDigitSplit #(.tField(fndTimePkg::centi_t)) u_centiSplit
    (
        .value (centiField),
        .tens  (splitDigits[6]),
        .ones  (splitDigits[7])
    );

    //////////////////////////////
    // Digit registers
    //////////////////////////////
    always_ff @(posedge iClk or posedge iRst)
    begin
        if (iRst)
        begin
            hourTens  <= '0;
            hourOnes  <= '0;
            minTens   <= '0;
            minOnes   <= '0;
            secTens   <= '0;
            secOnes   <= '0;
            centiTens <= '0;
            centiOnes <= '0;
            dotPhase  <= 1'b0;
        end
        else
        begin
            hourTens  <= splitDigits[0];
            hourOnes  <= splitDigits[1];
            minTens   <= splitDigits[2];
            minOnes   <= splitDigits[3];
            secTens   <= splitDigits[4];
            secOnes   <= splitDigits[5];
            centiTens <= splitDigits[6];
            centiOnes <= splitDigits[7];
            // Second half of every second
            dotPhase  <= (centiField >= fndTimePkg::centi_t'(`FND_DOT_THRESHOLD));
        end
    end

endmodule

/* design/timeDigitSplit.sv */
module timeDigitSplit
#(
    parameter type tField = logic [6:0]
)
(
    input  tField                 value,
    output fndTimePkg::bcdDigit_t tens,
    output fndTimePkg::bcdDigit_t ones
);

    // Two-digit fields only, anything above 99 wraps in the tens
    fndTimePkg::bcdDigit_t onesDigit;
    fndTimePkg::bcdDigit_t tensDigit;

    always_comb
    begin
        onesDigit = fndTimePkg::bcdDigit_t'(value % 10);
        tensDigit = fndTimePkg::bcdDigit_t'((value / 10) % 10);
    end

    assign ones = onesDigit;
    assign tens = tensDigit;

endmodule

/* design/fndPanelPkg.sv */
`include "fnd_settings.svh"

package fndPanelPkg;

    //////////////////////////////
    // Display mode
    //////////////////////////////

    // Odd values show hours:minutes, even values seconds:centiseconds
    typedef enum logic [2:0]
    {
        clockSec      = 3'd0,
        clockHour     = 3'd1,
        stopwatchSec  = 3'd2,
        stopwatchHour = 3'd3,
        timerSec      = 3'd4,
        timerHour     = 3'd5
    } displayMode_t;

    //////////////////////////////
    // Panel outputs
    //////////////////////////////

    // Common anode, active low, bit 7 is the decimal point
    typedef logic [7:0] segment_t;

    // Active-low digit commons
    typedef logic [`FND_DIGITS-1:0] digitEnable_t;

    // Scan position 0 is the rightmost digit
    typedef logic [$clog2(`FND_DIGITS)-1:0] position_t;

    // One LED per valid mode
    typedef logic [5:0] modeLed_t;

    typedef logic [3:0] alarmLed_t;

endpackage

/* design/fndTimePkg.sv */
`include "fnd_settings.svh"

package fndTimePkg;

    //////////////////////////////
    // Packed time from the clock core
    //////////////////////////////

    // Hours in the top bits, centiseconds at the bottom
    typedef logic [`FND_TIME_WIDTH-1:0] timeWord_t;

    // Individual fields, sized from their slice in the word
    typedef logic [`FND_HOUR_MSB-`FND_HOUR_LSB:0] hour_t;
    typedef logic [`FND_MIN_MSB-`FND_MIN_LSB:0] minute_t;
    typedef logic [`FND_SEC_MSB-`FND_SEC_LSB:0] second_t;
    typedef logic [`FND_CSEC_MSB-`FND_CSEC_LSB:0] centi_t;

    //////////////////////////////
    // Decimal digits
    //////////////////////////////

    // One BCD digit, 0 to 9 when legal
    typedef logic [3:0] bcdDigit_t;

endpackage

/* design/fnd_settings.svh */
`ifndef FND_SETTINGS_SVH
`define FND_SETTINGS_SVH

//////////////////////////////
// Time word field positions
//////////////////////////////
`define FND_HOUR_MSB 23
`define FND_HOUR_LSB 19
`define FND_MIN_MSB 18
`define FND_MIN_LSB 13
`define FND_SEC_MSB 12
`define FND_SEC_LSB 7
`define FND_CSEC_MSB 6
`define FND_CSEC_LSB 0
`define FND_TIME_WIDTH 24

//////////////////////////////
// Display scan
//////////////////////////////
`define FND_SCAN_DIV 100000
`define FND_DIGITS 4
`define FND_DOT_THRESHOLD 50

`endif
